/* source/cdc_fifo_defines.svh */
`ifndef CDC_FIFO_DEFINES_SVH
`define CDC_FIFO_DEFINES_SVH

// Number of storage entries, any value of 2 or more
`define CDC_FIFO_DEPTH 8

// Payload data bits carried in each entry
`define CDC_FIFO_DATA_WIDTH 16

// Flops per clock crossing in each synchronizer
`define CDC_FIFO_SYNC_STAGES 2

// Count bits, enough to hold 0 to depth and wrapping at a power of two
`define CDC_FIFO_COUNT_WIDTH 4

// Storage address bits
`define CDC_FIFO_ADDR_WIDTH 3

`endif

/* source/cdc_fifo_pkg.sv */
`include "cdc_fifo_defines.svh"

package cdc_fifo_pkg;

  // One beat count, held in binary inside a domain and in Gray code on the wire
  typedef logic [`CDC_FIFO_COUNT_WIDTH-1:0] count_t;

  // Index into the storage array
  typedef logic [`CDC_FIFO_ADDR_WIDTH-1:0] addr_t;

  // Payload with an end-of-packet marker
  typedef struct packed {
    logic [`CDC_FIFO_DATA_WIDTH-1:0] data;
    logic                            last;
  } fifo_entry_t;

  // What one domain reports to the other
  typedef struct packed {
    logic   reset_active;
    count_t count;
  } count_xfer_t;

  // Binary to Gray, only one bit changes per increment
  function automatic count_t bin2gray(input count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray to binary, each bit folds in all higher Gray bits
  function automatic count_t gray2bin(input count_t gray);
    count_t bin;
    bin[`CDC_FIFO_COUNT_WIDTH-1] = gray[`CDC_FIFO_COUNT_WIDTH-1];
    for (int i = `CDC_FIFO_COUNT_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* source/cdc_fifo_gray_sync.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_gray_sync
  import cdc_fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  count_xfer_t in_xfer,
  output count_xfer_t out_xfer
);

  localparam int STAGES = `CDC_FIFO_SYNC_STAGES;

  count_xfer_t sync_q [STAGES];

  // The reset value reports the far side as in reset until real data lands
  always_ff @(posedge clk) begin
    for (int i = 0; i < STAGES; i++) begin
      if (rst) begin
        sync_q[i] <= '{reset_active: 1'b1, count: '0};
      end else if (i == 0) begin
        sync_q[i] <= in_xfer;
      end else begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign out_xfer = sync_q[STAGES-1];

endmodule

/* source/cdc_fifo_ram.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_ram
  import cdc_fifo_pkg::*;
(
  input  logic        wr_clk,
  input  logic        wr_en,
  input  addr_t       wr_addr,
  input  fifo_entry_t wr_entry,
  input  addr_t       rd_addr,
  output fifo_entry_t rd_entry
);

  localparam int DEPTH = `CDC_FIFO_DEPTH;

  fifo_entry_t mem [DEPTH];

  // Written in the push domain only
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_entry;
    end
  end

  // Read port is combinational and used from the pop domain
  // The pop side only addresses entries whose count has already crossed
  assign rd_entry = mem[rd_addr];

  // A write past the last entry would be lost
  wr_addr_range_a: assert property (@(posedge wr_clk)
    wr_en |-> (int'(wr_addr) < DEPTH));

endmodule

/* source/cdc_fifo_push_flag_mgr.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_push_flag_mgr
  import cdc_fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        push_beat,
  output count_xfer_t push_xfer,
  input  count_xfer_t pop_xfer,
  output count_t      slots,
  output logic        full
);

  localparam int CW = `CDC_FIFO_COUNT_WIDTH;
  localparam int DEPTH = `CDC_FIFO_DEPTH;
  // One stage more than the reset_active delay, so the pop side sees the flag first
  localparam int COUNT_DELAY = 2;
  localparam logic [CW:0] WRAP_OFFSET = (CW + 1)'(2 ** CW);

  logic              reset_active_push;
  count_t            push_count;
  count_t            push_count_next;
  count_t            push_gray_next;
  count_t            gray_dly [COUNT_DELAY];
  count_t            pop_count;
  count_t            pop_count_saved;
  count_t            pop_count_visible;
  logic   [CW:0]     push_ext;
  logic   [CW:0]     pop_ext;
  logic   [CW:0]     items_next;
  count_t            slots_next;
  logic              full_next;

  // Local beat count, wraps naturally at the count width
  assign push_count_next = push_count + count_t'(push_beat);
  assign push_gray_next = bin2gray(push_count_next);

  always_ff @(posedge clk) begin
    if (rst) begin
      push_count <= '0;
    end else begin
      push_count <= push_count_next;
    end
  end

  // Local reset seen by the far side, one flop behind rst
  always_ff @(posedge clk) begin
    reset_active_push <= rst;
  end

  // The Gray count trails the beat by two cycles, which also covers the storage write
  always_ff @(posedge clk) begin
    for (int i = 0; i < COUNT_DELAY; i++) begin
      if (rst) begin
        gray_dly[i] <= '0;
      end else if (i == 0) begin
        gray_dly[i] <= push_gray_next;
      end else begin
        gray_dly[i] <= gray_dly[i-1];
      end
    end
  end

  assign push_xfer.reset_active = reset_active_push;
  assign push_xfer.count = gray_dly[COUNT_DELAY-1];

  // Pop count as it arrived through the synchronizer
  assign pop_count = gray2bin(pop_xfer.count);

  // Remember the last good pop count, it stands in while the pop side is in reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_count_saved <= '0;
    end else if (!pop_xfer.reset_active) begin
      pop_count_saved <= pop_count;
    end
  end

  assign pop_count_visible = pop_xfer.reset_active ? pop_count_saved : pop_count;

  // Occupancy with one extra bit so the push count can be lifted past a wrap
  assign push_ext = {1'b0, push_count_next};
  assign pop_ext = {1'b0, pop_count_visible};
  assign items_next = (push_ext >= pop_ext) ? (push_ext - pop_ext)
                                            : (push_ext + WRAP_OFFSET - pop_ext);
  assign slots_next = count_t'(DEPTH) - items_next[CW-1:0];
  assign full_next = (slots_next == '0);

  // Flags freeze while the pop side is in reset unless we push ourselves
  always_ff @(posedge clk) begin
    if (rst) begin
      slots <= count_t'(DEPTH);
      full <= 1'b0;
    end else if (push_beat || !pop_xfer.reset_active) begin
      slots <= slots_next;
      full <= full_next;
    end
  end

  // Occupancy must never pass the depth, whatever the pop count does
  no_overflow_a: assert property (@(posedge clk) disable iff (rst)
    items_next <= (CW + 1)'(DEPTH));

  // The push control must hold off beats once full
  no_push_when_full_a: assert property (@(posedge clk) disable iff (rst)
    !(push_beat && full));

endmodule

/* source/cdc_fifo_push_ctrl.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_push_ctrl
  import cdc_fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        push_valid,
  output logic        push_ready,
  input  fifo_entry_t push_entry,
  output logic        wr_en,
  output addr_t       wr_addr,
  output fifo_entry_t wr_entry,
  input  count_xfer_t pop_xfer,
  output count_xfer_t push_xfer,
  output count_t      push_slots
);

  localparam int DEPTH = `CDC_FIFO_DEPTH;

  logic push_en;
  logic push_beat;
  logic full;

  // Acceptance opens on the first edge after reset
  always_ff @(posedge clk) begin
    push_en <= !rst;
  end

  assign push_ready = push_en && !full;
  assign push_beat = push_valid && push_ready;

  // Every beat goes straight into storage
  assign wr_en = push_beat;
  assign wr_entry = push_entry;

  // Write pointer, depth need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr <= '0;
    end else if (push_beat) begin
      wr_addr <= (wr_addr == addr_t'(DEPTH - 1)) ? '0 : wr_addr + addr_t'(1);
    end
  end

  cdc_fifo_push_flag_mgr u_push_flag_mgr (
    .clk       (clk),
    .rst       (rst),
    .push_beat (push_beat),
    .push_xfer (push_xfer),
    .pop_xfer  (pop_xfer),
    .slots     (push_slots),
    .full      (full)
  );

  // An offered entry may not change until it is taken
  push_stable_a: assert property (@(posedge clk) disable iff (rst)
    push_valid && !push_ready |=> $stable(push_entry));

endmodule

/* source/cdc_fifo_pop_flag_mgr.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_pop_flag_mgr
  import cdc_fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        pop_beat,
  input  count_xfer_t push_xfer,
  output count_xfer_t pop_xfer,
  output count_t      items,
  output logic        empty
);

  localparam int CW = `CDC_FIFO_COUNT_WIDTH;
  localparam logic [CW:0] WRAP_OFFSET = (CW + 1)'(2 ** CW);

  count_t        pop_count;
  count_t        pop_count_next;
  count_t        push_count;
  count_t        push_count_saved;
  count_t        push_count_visible;
  logic   [CW:0] push_ext;
  logic   [CW:0] pop_ext;
  logic   [CW:0] items_next;

  // Reads taken from storage so far
  assign pop_count_next = pop_count + count_t'(pop_beat);

  always_ff @(posedge clk) begin
    if (rst) begin
      pop_count <= '0;
    end else begin
      pop_count <= pop_count_next;
    end
  end

  // Reset flag and Gray count leave together from one register
  always_ff @(posedge clk) begin
    pop_xfer.reset_active <= rst;
    if (rst) begin
      pop_xfer.count <= '0;
    end else begin
      pop_xfer.count <= bin2gray(pop_count_next);
    end
  end

  assign push_count = gray2bin(push_xfer.count);

  // Hold the last push count seen before the push side went into reset
  always_ff @(posedge clk) begin
    if (rst) begin
      push_count_saved <= '0;
    end else if (!push_xfer.reset_active) begin
      push_count_saved <= push_count;
    end
  end

  assign push_count_visible = push_xfer.reset_active ? push_count_saved : push_count;

  // Entries still in storage, with the wrap of the push count compensated
  assign push_ext = {1'b0, push_count_visible};
  assign pop_ext = {1'b0, pop_count_next};
  assign items_next = (push_ext >= pop_ext) ? (push_ext - pop_ext)
                                            : (push_ext + WRAP_OFFSET - pop_ext);

  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
      empty <= 1'b1;
    end else if (pop_beat || !push_xfer.reset_active) begin
      items <= items_next[CW-1:0];
      empty <= (items_next == '0);
    end
  end

  // Storage is never read past what the push side has published
  no_read_when_empty_a: assert property (@(posedge clk) disable iff (rst)
    !(pop_beat && empty));

endmodule

/* source/cdc_fifo_pop_ctrl.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_pop_ctrl
  import cdc_fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output logic        pop_valid,
  input  logic        pop_ready,
  output fifo_entry_t pop_entry,
  output addr_t       rd_addr,
  input  fifo_entry_t rd_entry,
  input  count_xfer_t push_xfer,
  output count_xfer_t pop_xfer,
  output count_t      pop_items
);

  localparam int DEPTH = `CDC_FIFO_DEPTH;

  logic empty;
  logic rd_beat;

  // Refill the output register when it is free or leaving this cycle
  assign rd_beat = !empty && (!pop_valid || pop_ready);

  // Read pointer follows the same wrap as the write pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (rd_beat) begin
      rd_addr <= (rd_addr == addr_t'(DEPTH - 1)) ? '0 : rd_addr + addr_t'(1);
    end
  end

  // Output valid stays up while the entry waits or a new one arrives
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_valid <= 1'b0;
    end else if (rd_beat) begin
      pop_valid <= 1'b1;
    end else if (pop_ready) begin
      pop_valid <= 1'b0;
    end
  end

  // Payload register, loaded only on a read
  always_ff @(posedge clk) begin
    if (rd_beat) begin
      pop_entry <= rd_entry;
    end
  end

  cdc_fifo_pop_flag_mgr u_pop_flag_mgr (
    .clk       (clk),
    .rst       (rst),
    .pop_beat  (rd_beat),
    .push_xfer (push_xfer),
    .pop_xfer  (pop_xfer),
    .items     (pop_items),
    .empty     (empty)
  );

  // Under back-pressure the presented entry must hold
  pop_stable_a: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_entry));

endmodule

/* source/cdc_fifo.sv */
`timescale 1ns/10ps

module cdc_fifo
  import cdc_fifo_pkg::*;
(
  input  logic        push_clk,
  input  logic        pop_clk,
  input  logic        rst,
  input  logic        push_valid,
  output logic        push_ready,
  input  fifo_entry_t push_entry,
  output logic        pop_valid,
  input  logic        pop_ready,
  output fifo_entry_t pop_entry,
  output count_t      push_slots,
  output count_t      pop_items
);

  logic        wr_en;
  addr_t       wr_addr;
  fifo_entry_t wr_entry;
  addr_t       rd_addr;
  fifo_entry_t rd_entry;
  // Counts as sent and as received in each direction
  count_xfer_t push_xfer_src;
  count_xfer_t push_xfer_dst;
  count_xfer_t pop_xfer_src;
  count_xfer_t pop_xfer_dst;

  cdc_fifo_push_ctrl u_push_ctrl (
    .clk        (push_clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_entry (push_entry),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_entry   (wr_entry),
    .pop_xfer   (pop_xfer_dst),
    .push_xfer  (push_xfer_src),
    .push_slots (push_slots)
  );

  cdc_fifo_ram u_ram (
    .wr_clk   (push_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_entry (wr_entry),
    .rd_addr  (rd_addr),
    .rd_entry (rd_entry)
  );

  // Push count into the pop domain
  cdc_fifo_gray_sync u_push_to_pop_sync (
    .clk      (pop_clk),
    .rst      (rst),
    .in_xfer  (push_xfer_src),
    .out_xfer (push_xfer_dst)
  );

  // Pop count into the push domain
  cdc_fifo_gray_sync u_pop_to_push_sync (
    .clk      (push_clk),
    .rst      (rst),
    .in_xfer  (pop_xfer_src),
    .out_xfer (pop_xfer_dst)
  );

  cdc_fifo_pop_ctrl u_pop_ctrl (
    .clk       (pop_clk),
    .rst       (rst),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_entry (pop_entry),
    .rd_addr   (rd_addr),
    .rd_entry  (rd_entry),
    .push_xfer (push_xfer_dst),
    .pop_xfer  (pop_xfer_src),
    .pop_items (pop_items)
  );

endmodule

/* tb/cdc_fifo_tb.sv */
`timescale 1ns/10ps
`include "cdc_fifo_defines.svh"

module cdc_fifo_tb
  import cdc_fifo_pkg::*;
();

  localparam int DEPTH = `CDC_FIFO_DEPTH;
  localparam count_t DEPTH_COUNT = count_t'(DEPTH);
  localparam int WAIT_LIMIT = 100;
  localparam int DRAIN_LIMIT = 400;
  // Pop side behaviour, chosen by the main sequence
  localparam int POP_RANDOM = 0;
  localparam int POP_HOLD = 1;
  localparam int POP_DRAIN = 2;

  logic        push_clk;
  logic        pop_clk;
  logic        rst;
  logic        push_valid;
  logic        push_ready;
  fifo_entry_t push_entry;
  logic        pop_valid;
  logic        pop_ready;
  fifo_entry_t pop_entry;
  count_t      push_slots;
  count_t      pop_items;

  // Scoreboard of accepted entries, oldest at the front
  fifo_entry_t model_q[$];
  int          pushed_cnt;
  int          popped_cnt;
  int          errors;
  int          timeouts;
  int          pop_mode;
  int          fill_accepts;
  logic        fill_phase;
  logic        drain_done;
  logic        push_fire;
  logic [31:0] push_rng;
  logic [31:0] pop_rng;
  logic        push_rst_q;
  logic        pop_rst_q;
  // Last pop beat, checked on the following pop_clk edge
  logic        cmp_valid;
  logic        cmp_underflow;
  fifo_entry_t cmp_got;
  fifo_entry_t cmp_exp;

  cdc_fifo u_cdc_fifo (
    .push_clk   (push_clk),
    .pop_clk    (pop_clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_entry (push_entry),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_entry  (pop_entry),
    .push_slots (push_slots),
    .pop_items  (pop_items)
  );

  always #10 push_clk = ~push_clk;

  // Same period, shifted by 7 ns so no edge ever meets a push_clk edge
  always begin
    #7;
    forever #10 pop_clk = ~pop_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Remembers whether the previous edge was still in reset
  always @(posedge push_clk) push_rst_q <= rst;
  always @(posedge pop_clk) pop_rst_q <= rst;

  // One push_clk cycle of stimulus, a new entry is chosen only after the old one was taken
  task automatic push_step(input logic want);
    @(negedge push_clk);
    if (push_fire) begin
      push_rng = xorshift32(push_rng);
      push_entry = '{data: push_rng[`CDC_FIFO_DATA_WIDTH-1:0], last: push_rng[31]};
    end
    push_valid = want;
    // push_ready only moves on push_clk edges, so this is the beat of the next edge
    push_fire = push_valid && push_ready;
    if (push_fire) begin
      model_q.push_back(push_entry);
      pushed_cnt++;
      if (fill_phase) begin
        fill_accepts++;
      end
    end
  endtask

  task automatic push_random(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      push_rng = xorshift32(push_rng);
      push_step(push_rng[2:0] != 3'b000);
    end
  endtask

  task automatic wait_slots_return;
    int n;
    n = 0;
    push_step(1'b0);
    while (push_slots != DEPTH_COUNT && n < WAIT_LIMIT) begin
      push_step(1'b0);
      n++;
    end
    if (push_slots != DEPTH_COUNT) begin
      timeouts++;
      $display("Timeout at %0t: push_slots did not return to the depth", $time);
    end
  endtask

  // Stops pushing, pops everything and waits for the freed slots to come back
  task automatic drain_fifo;
    int n;
    n = 0;
    pop_mode = POP_DRAIN;
    push_step(1'b0);
    while ((pushed_cnt != popped_cnt || pop_valid) && n < DRAIN_LIMIT) begin
      push_step(1'b0);
      n++;
    end
    if (pushed_cnt != popped_cnt || pop_valid) begin
      timeouts++;
      $display("Timeout at %0t: the FIFO did not drain, %0d entries left",
               $time, pushed_cnt - popped_cnt);
    end
    wait_slots_return();
  endtask

  task automatic fill_test;
    int n;
    drain_fifo();
    pop_mode = POP_HOLD;
    // One entry goes ahead and parks in the pop output register
    n = 0;
    push_step(1'b1);
    while (!push_fire && n < WAIT_LIMIT) begin
      push_step(1'b1);
      n++;
    end
    if (!push_fire) begin
      timeouts++;
      $display("Timeout at %0t: the entry to park was never accepted", $time);
    end
    push_step(1'b0);
    n = 0;
    while (!pop_valid && n < WAIT_LIMIT) begin
      push_step(1'b0);
      n++;
    end
    if (!pop_valid) begin
      timeouts++;
      $display("Timeout at %0t: pop_valid never rose for the parked entry", $time);
    end
    wait_slots_return();
    // Storage is now empty behind a stalled output, so exactly the depth fits
    fill_accepts = 0;
    fill_phase = 1'b1;
    repeat (DEPTH + 4) push_step(1'b1);
    fill_phase = 1'b0;
    push_step(1'b0);
    pop_mode = POP_RANDOM;
  endtask

  // Pop side driver and scoreboard, pop_valid and pop_entry are steady here
  always @(negedge pop_clk) begin
    if (rst) begin
      pop_ready = 1'b0;
      cmp_valid = 1'b0;
    end else begin
      pop_rng = xorshift32(pop_rng);
      case (pop_mode)
        POP_HOLD:  pop_ready = 1'b0;
        POP_DRAIN: pop_ready = 1'b1;
        default:   pop_ready = (pop_rng[1:0] != 2'b00);
      endcase
      cmp_valid = pop_valid && pop_ready;
      if (cmp_valid) begin
        cmp_got = pop_entry;
        cmp_underflow = (model_q.size() == 0);
        if (!cmp_underflow) begin
          cmp_exp = model_q.pop_front();
        end
        popped_cnt++;
      end
    end
  end

  order_a: assert property (@(posedge pop_clk) disable iff (rst)
    cmp_valid |-> !cmp_underflow && cmp_got == cmp_exp)
    else begin
      errors++;
      $display("FAILED at %0t: popped %h but oldest pushed entry is %h",
               $time, cmp_got, cmp_exp);
    end

  full_after_fill_a: assert property (@(posedge push_clk) disable iff (rst)
    fill_phase && push_valid && push_ready && push_slots == count_t'(1)
    |=> !push_ready && push_slots == '0)
    else begin
      errors++;
      $display("FAILED at %0t: FIFO not full after the filling push", $time);
    end

  // Never more than the depth while filling, and exactly the depth once ready drops
  fill_count_a: assert property (@(posedge push_clk) disable iff (rst)
    fill_phase |-> fill_accepts <= DEPTH && (push_ready || fill_accepts == DEPTH))
    else begin
      errors++;
      $display("FAILED at %0t: %0d pushes accepted before full", $time, fill_accepts);
    end

  pop_hold_a: assert property (@(posedge pop_clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_entry))
    else begin
      errors++;
      $display("FAILED at %0t: pop output changed under back-pressure", $time);
    end

  // Reset values, checked from the second reset edge to the first edge after it
  push_reset_a: assert property (@(posedge push_clk)
    push_rst_q |-> !push_ready && push_slots == DEPTH_COUNT)
    else begin
      errors++;
      $display("FAILED at %0t: push side reset values wrong, slots %0d", $time, push_slots);
    end

  pop_reset_a: assert property (@(posedge pop_clk)
    pop_rst_q |-> !pop_valid && pop_items == '0)
    else begin
      errors++;
      $display("FAILED at %0t: pop side reset values wrong, items %0d", $time, pop_items);
    end

  slots_range_a: assert property (@(posedge push_clk) disable iff (rst)
    push_slots <= DEPTH_COUNT)
    else begin
      errors++;
      $display("FAILED at %0t: push_slots %0d above the depth", $time, push_slots);
    end

  items_range_a: assert property (@(posedge pop_clk) disable iff (rst)
    int'(pop_items) <= pushed_cnt - popped_cnt)
    else begin
      errors++;
      $display("FAILED at %0t: pop_items %0d above the %0d entries in flight",
               $time, pop_items, pushed_cnt - popped_cnt);
    end

  drained_push_a: assert property (@(posedge push_clk)
    drain_done |-> push_slots == DEPTH_COUNT)
    else begin
      errors++;
      $display("FAILED at %0t: push_slots %0d after drain", $time, push_slots);
    end

  drained_pop_a: assert property (@(posedge pop_clk)
    drain_done |-> !pop_valid && pop_items == '0)
    else begin
      errors++;
      $display("FAILED at %0t: pop side not empty after drain", $time);
    end

  initial begin
    push_clk = 1'b0;
    pop_clk = 1'b0;
    rst = 1'b1;
    push_valid = 1'b0;
    pop_ready = 1'b0;
    push_rng = 32'd86;
    pop_rng = xorshift32(32'd86);
    push_entry = '{data: push_rng[`CDC_FIFO_DATA_WIDTH-1:0], last: 1'b0};
    pushed_cnt = 0;
    popped_cnt = 0;
    errors = 0;
    timeouts = 0;
    pop_mode = POP_RANDOM;
    fill_accepts = 0;
    fill_phase = 1'b0;
    drain_done = 1'b0;
    push_fire = 1'b0;
    push_rst_q = 1'b0;
    pop_rst_q = 1'b0;
    cmp_valid = 1'b0;
    cmp_underflow = 1'b0;
    cmp_got = '0;
    cmp_exp = '0;
    repeat (8) @(posedge push_clk);
    @(negedge push_clk);
    rst = 1'b0;
    push_random(400);
    // A long stall of the pop side backs the FIFO up
    pop_mode = POP_HOLD;
    push_random(60);
    pop_mode = POP_RANDOM;
    push_random(300);
    fill_test();
    push_random(300);
    drain_fifo();
    drain_done = 1'b1;
    repeat (5) @(negedge push_clk);
    $display("Summary: %0d entries moved, %0d check failures, %0d timeouts",
             popped_cnt, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* cdc_fifo.f */
+incdir+source
source/cdc_fifo_pkg.sv
source/cdc_fifo_gray_sync.sv
source/cdc_fifo_ram.sv
source/cdc_fifo_push_flag_mgr.sv
source/cdc_fifo_push_ctrl.sv
source/cdc_fifo_pop_flag_mgr.sv
source/cdc_fifo_pop_ctrl.sv
source/cdc_fifo.sv
tb/cdc_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cdc_fifo testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=cdc_fifo_sim

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module cdc_fifo_tb -f cdc_fifo.f -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
